// File: source/ospfb_config.svh
`ifndef OSPFB_CONFIG_SVH
`define OSPFB_CONFIG_SVH

// bits per real or imaginary part
`define OSPFB_WIDTH 16

// coefficient word and its fraction bits, 1.0 is 1 << 14
`define OSPFB_COEFF_WID 16
`define OSPFB_COEFF_FRAC 14

// branches per frame (M), also the fft length downstream
`define OSPFB_FFT_LEN 8
// new samples per frame (D)
`define OSPFB_DEC_FAC 6
// taps per polyphase branch
`define OSPFB_PTAPS 2

// clock crossing fifo, power of two
`define OSPFB_FIFO_DEPTH 8

// frame counter width on tuser
`define OSPFB_USER_WID 8

`endif

// File: source/ospfb_types_pkg.sv
`include "ospfb_config.svh"

package ospfb_types_pkg;

  // one real or imaginary part
  typedef logic signed [`OSPFB_WIDTH-1:0] sample_t;

  // stream word, re in the low half
  typedef struct packed {
    sample_t im;
    sample_t re;
  } cplx_t;

  typedef logic signed [`OSPFB_COEFF_WID-1:0] coeff_t;

  // full product plus growth over the taps of one branch
  typedef logic signed [`OSPFB_WIDTH+`OSPFB_COEFF_WID+$clog2(`OSPFB_PTAPS)-1:0] acc_t;

  typedef logic [$clog2(`OSPFB_FFT_LEN)-1:0] branch_idx_t;
  typedef logic [`OSPFB_USER_WID-1:0] frame_id_t;

  // single cycle event pulses
  typedef struct packed {
    logic frame_started;
    logic tlast_unexpected;
    logic tlast_missing;
  } ospfb_events_t;

  typedef enum logic [1:0] {seq_collect, seq_emit, seq_drain} seq_state_t;

endpackage

// File: source/ospfb_coeff_pkg.sv
`include "ospfb_config.svh"

package ospfb_coeff_pkg;

  localparam int NUM_TAPS = `OSPFB_FFT_LEN * `OSPFB_PTAPS;
  localparam int UNITY = 1 << `OSPFB_COEFF_FRAC;

  // indexed p*M + m, p the tap and m the branch
  typedef ospfb_types_pkg::coeff_t tap_table_t [NUM_TAPS];

  // branch m gets (m+1)/M of unity
  // each later tap is pulled down by 1/64 so no two entries match
  function automatic tap_table_t make_taps();
    tap_table_t t;
    for (int i = 0; i < NUM_TAPS; i++) begin
      t[i] = ospfb_types_pkg::coeff_t'(((i % `OSPFB_FFT_LEN) + 1) * UNITY / `OSPFB_FFT_LEN
                                       - (i / `OSPFB_FFT_LEN) * UNITY / 64);
    end
    return t;
  endfunction

  parameter tap_table_t taps = make_taps();

endpackage

// File: source/cdc_axis_fifo.sv
`timescale 1ns/1ps
`include "ospfb_config.svh"

module cdc_axis_fifo #(
  parameter int DEPTH = `OSPFB_FIFO_DEPTH
) (
  input wire logic s_aclk,
  input wire logic m_aclk,
  input wire logic reset,
  input wire ospfb_types_pkg::cplx_t s_data,
  input wire logic s_last,
  input wire logic s_valid,
  output logic s_ready,
  output ospfb_types_pkg::cplx_t m_data,
  output logic m_last,
  output logic m_valid,
  input wire logic m_ready
);
  import ospfb_types_pkg::*;

  localparam int AW = $clog2(DEPTH);
  // gray pointers one lap apart differ in their top two bits only
  localparam logic [AW:0] FULL_DIFF = 3 << (AW - 1);

  function automatic logic [AW:0] to_gray(input logic [AW:0] b);
    return b ^ (b >> 1);
  endfunction

  cplx_t mem_data [DEPTH];
  logic mem_last [DEPTH];

  // extra msb on each pointer tells full from empty
  logic [AW:0] wbin, wbin_nxt, wgray;
  logic [AW:0] rbin, rbin_nxt, rgray;
  // two flop synchronizers, one per direction
  logic [AW:0] rgray_s1, rgray_s2;
  logic [AW:0] wgray_s1, wgray_s2;
  logic wr_live, full, empty, push, pop;

  // write side, s_aclk
  assign full = ((wgray ^ rgray_s2) == FULL_DIFF);
  // held low until the first clock out of reset
  assign s_ready = wr_live & ~full;
  assign push = s_valid & s_ready;
  assign wbin_nxt = wbin + push;

  always_ff @(posedge s_aclk) begin
    if (reset) begin
      wr_live <= 1'b0;
      wbin <= '0;
      wgray <= '0;
      rgray_s1 <= '0;
      rgray_s2 <= '0;
    end else begin
      wr_live <= 1'b1;
      wbin <= wbin_nxt;
      wgray <= to_gray(wbin_nxt);
      rgray_s1 <= rgray;
      rgray_s2 <= rgray_s1;
    end
  end

  always_ff @(posedge s_aclk) begin
    if (push) begin
      mem_data[wbin[AW-1:0]] <= s_data;
      mem_last[wbin[AW-1:0]] <= s_last;
    end
  end

  // read side, m_aclk
  assign empty = (rgray == wgray_s2);
  // refill output word when it is free or leaving
  assign pop = ~empty & (~m_valid | m_ready);
  assign rbin_nxt = rbin + pop;

  always_ff @(posedge m_aclk) begin
    if (reset) begin
      rbin <= '0;
      rgray <= '0;
      wgray_s1 <= '0;
      wgray_s2 <= '0;
      m_valid <= 1'b0;
    end else begin
      rbin <= rbin_nxt;
      rgray <= to_gray(rbin_nxt);
      wgray_s1 <= wgray;
      wgray_s2 <= wgray_s1;
      if (pop) begin
        m_valid <= 1'b1;
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
    end
  end

  // registered output word
  always_ff @(posedge m_aclk) begin
    if (pop) begin
      m_data <= mem_data[rbin[AW-1:0]];
      m_last <= mem_last[rbin[AW-1:0]];
    end
  end

endmodule

// File: source/pfb_history.sv
`timescale 1ns/1ps
`include "ospfb_config.svh"

module pfb_history (
  input wire logic clk,
  input wire logic reset,
  input wire ospfb_types_pkg::cplx_t data,
  input wire logic last,
  input wire logic valid,
  output logic ready,
  input wire logic accept,
  output ospfb_types_pkg::cplx_t hist [`OSPFB_FFT_LEN*`OSPFB_PTAPS],
  output logic frame_full,
  output ospfb_types_pkg::ospfb_events_t events_tlast
);
  import ospfb_types_pkg::*;

  localparam int HIST_LEN = `OSPFB_FFT_LEN * `OSPFB_PTAPS;
  // D < M, so the position fits a branch index
  localparam branch_idx_t POS_LAST = branch_idx_t'(`OSPFB_DEC_FAC - 1);

  branch_idx_t pos;
  logic take;
  logic at_end;

  // sequencer alone decides when samples may enter
  assign ready = accept;
  assign take = valid & ready;
  assign at_end = (pos == POS_LAST);

  always_ff @(posedge clk) begin
    if (reset) begin
      pos <= '0;
      frame_full <= 1'b0;
      events_tlast <= '0;
      for (int i = 0; i < HIST_LEN; i++) begin
        hist[i] <= '0;
      end
    end else begin
      // pulses follow the accepting edge by one cycle
      frame_full <= take & at_end;
      events_tlast.frame_started <= 1'b0;
      events_tlast.tlast_unexpected <= take & last & ~at_end;
      events_tlast.tlast_missing <= take & ~last & at_end;
      if (take) begin
        // newest sample at index 0
        hist[0] <= data;
        for (int i = 1; i < HIST_LEN; i++) begin
          hist[i] <= hist[i-1];
        end
        // counts modulo D, tlast does not resync it
        pos <= at_end ? '0 : pos + 1'b1;
      end
    end
  end

endmodule

// File: source/pfb_branch_sum.sv
`timescale 1ns/1ps
`include "ospfb_config.svh"

module pfb_branch_sum (
  input wire logic clk,
  input wire logic reset,
  input wire ospfb_types_pkg::cplx_t hist [`OSPFB_FFT_LEN*`OSPFB_PTAPS],
  input wire ospfb_types_pkg::branch_idx_t branch_sel,
  input wire logic sum_req,
  output ospfb_types_pkg::cplx_t sum,
  output logic sum_valid
);
  import ospfb_types_pkg::*;
  import ospfb_coeff_pkg::*;

  acc_t acc_re;
  acc_t acc_im;

  // branch m uses history and taps at p*M + m
  always_comb begin
    acc_re = '0;
    acc_im = '0;
    for (int p = 0; p < `OSPFB_PTAPS; p++) begin
      acc_re += acc_t'(taps[p*`OSPFB_FFT_LEN + branch_sel])
              * acc_t'(hist[p*`OSPFB_FFT_LEN + branch_sel].re);
      acc_im += acc_t'(taps[p*`OSPFB_FFT_LEN + branch_sel])
              * acc_t'(hist[p*`OSPFB_FFT_LEN + branch_sel].im);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= sum_req;
    end
  end

  // drop the coefficient fraction, keep the low part bits
  // sum holds its value until the next request
  always_ff @(posedge clk) begin
    if (sum_req) begin
      sum.re <= sample_t'(acc_re >>> `OSPFB_COEFF_FRAC);
      sum.im <= sample_t'(acc_im >>> `OSPFB_COEFF_FRAC);
    end
  end

endmodule

// File: source/ospfb_sequencer.sv
`timescale 1ns/1ps
`include "ospfb_config.svh"

module ospfb_sequencer (
  input wire logic clk,
  input wire logic reset,
  input wire logic en,
  input wire logic frame_full,
  output logic accept,
  output ospfb_types_pkg::branch_idx_t branch_sel,
  output logic sum_req,
  input wire ospfb_types_pkg::cplx_t sum,
  input wire logic sum_valid,
  output ospfb_types_pkg::cplx_t out_data,
  output ospfb_types_pkg::frame_id_t out_user,
  output logic out_valid,
  output logic out_last,
  input wire logic out_ready,
  output logic frame_started
);
  import ospfb_types_pkg::*;

  localparam branch_idx_t LAST_IDX = branch_idx_t'(`OSPFB_FFT_LEN - 1);
  // per frame phase advance, D mod M
  localparam branch_idx_t ROT_STEP = branch_idx_t'(`OSPFB_DEC_FAC % `OSPFB_FFT_LEN);

  seq_state_t state;
  // next output index to request
  branch_idx_t req_k;
  // index of the next word entering the output register
  branch_idx_t out_k;
  // oversampling phase s
  branch_idx_t rot;
  frame_id_t frame_cnt;
  logic pend_q;
  logic pending;
  logic load;

  // a finished sum waits in the summer until the output frees
  assign pending = sum_valid | pend_q;
  assign load = pending & (~out_valid | out_ready);

  assign accept = (state == seq_collect) & en & ~frame_full;
  // one sum in flight at most
  assign sum_req = (state == seq_emit) & (~pending | load);
  // circular shift, output k carries branch (k - s) mod M
  assign branch_sel = req_k - rot;
  assign out_user = frame_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= seq_collect;
      req_k <= '0;
      rot <= '0;
      frame_cnt <= '0;
    end else begin
      case (state)
        seq_collect: begin
          if (frame_full) begin
            state <= seq_emit;
            req_k <= '0;
          end
        end
        seq_emit: begin
          if (sum_req) begin
            req_k <= req_k + 1'b1;
            if (req_k == LAST_IDX) begin
              state <= seq_drain;
            end
          end
        end
        seq_drain: begin
          // history stays frozen until the frame is gone
          if (out_valid && out_ready && out_last) begin
            state <= seq_collect;
            frame_cnt <= frame_cnt + 1'b1;
            rot <= rot + ROT_STEP;
          end
        end
        default: state <= seq_collect;
      endcase
    end
  end

  // output register and framing flags
  always_ff @(posedge clk) begin
    if (reset) begin
      pend_q <= 1'b0;
      out_valid <= 1'b0;
      out_last <= 1'b0;
      out_k <= '0;
      frame_started <= 1'b0;
    end else begin
      pend_q <= pending & ~load;
      frame_started <= load & (out_k == '0);
      if (load) begin
        out_valid <= 1'b1;
        out_last <= (out_k == LAST_IDX);
        out_k <= out_k + 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
        out_last <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= sum;
    end
  end

endmodule

// File: source/ospfb.sv
`timescale 1ns/1ps
`include "ospfb_config.svh"

module ospfb (
  input wire logic clk,
  input wire logic reset,
  input wire logic en,
  input wire ospfb_types_pkg::cplx_t s_axis_tdata,
  input wire logic s_axis_tlast,
  input wire logic s_axis_tvalid,
  output logic s_axis_tready,
  output ospfb_types_pkg::cplx_t m_axis_tdata,
  output ospfb_types_pkg::frame_id_t m_axis_tuser,
  output logic m_axis_tvalid,
  output logic m_axis_tlast,
  input wire logic m_axis_tready,
  output ospfb_types_pkg::ospfb_events_t events
);
  import ospfb_types_pkg::*;

  cplx_t hist [`OSPFB_FFT_LEN*`OSPFB_PTAPS];
  cplx_t sum;
  branch_idx_t branch_sel;
  ospfb_events_t events_tlast;
  logic accept;
  logic frame_full;
  logic sum_req;
  logic sum_valid;
  logic frame_started;

  pfb_history history_inst (
    .clk(clk),
    .reset(reset),
    .data(s_axis_tdata),
    .last(s_axis_tlast),
    .valid(s_axis_tvalid),
    .ready(s_axis_tready),
    .accept(accept),
    .hist(hist),
    .frame_full(frame_full),
    .events_tlast(events_tlast)
  );

  pfb_branch_sum branch_sum_inst (
    .clk(clk),
    .reset(reset),
    .hist(hist),
    .branch_sel(branch_sel),
    .sum_req(sum_req),
    .sum(sum),
    .sum_valid(sum_valid)
  );

  ospfb_sequencer sequencer_inst (
    .clk(clk),
    .reset(reset),
    .en(en),
    .frame_full(frame_full),
    .accept(accept),
    .branch_sel(branch_sel),
    .sum_req(sum_req),
    .sum(sum),
    .sum_valid(sum_valid),
    .out_data(m_axis_tdata),
    .out_user(m_axis_tuser),
    .out_valid(m_axis_tvalid),
    .out_last(m_axis_tlast),
    .out_ready(m_axis_tready),
    .frame_started(frame_started)
  );

  // input framing events merged with the output frame start
  assign events = events_tlast | ospfb_events_t'{frame_started: frame_started, default: 1'b0};

endmodule

// File: source/ospfb_top.sv
`timescale 1ns/1ps
`include "ospfb_config.svh"

module ospfb_top (
  // adc side clock
  input wire logic s_axis_aclk,
  // dsp side clock
  input wire logic m_axis_aclk,
  input wire logic reset,
  input wire logic en,
  input wire ospfb_types_pkg::cplx_t s_axis_tdata,
  input wire logic s_axis_tvalid,
  input wire logic s_axis_tlast,
  output logic s_axis_tready,
  output ospfb_types_pkg::cplx_t m_axis_tdata,
  output ospfb_types_pkg::frame_id_t m_axis_tuser,
  output logic m_axis_tvalid,
  output logic m_axis_tlast,
  input wire logic m_axis_tready,
  output ospfb_types_pkg::ospfb_events_t events
);
  import ospfb_types_pkg::*;

  // fifo to core stream, m_axis_aclk domain
  cplx_t core_tdata;
  logic core_tlast;
  logic core_tvalid;
  logic core_tready;

  cdc_axis_fifo #(
    .DEPTH(`OSPFB_FIFO_DEPTH)
  ) fifo_inst (
    .s_aclk(s_axis_aclk),
    .m_aclk(m_axis_aclk),
    .reset(reset),
    .s_data(s_axis_tdata),
    .s_last(s_axis_tlast),
    .s_valid(s_axis_tvalid),
    .s_ready(s_axis_tready),
    .m_data(core_tdata),
    .m_last(core_tlast),
    .m_valid(core_tvalid),
    .m_ready(core_tready)
  );

  ospfb ospfb_inst (
    .clk(m_axis_aclk),
    .reset(reset),
    .en(en),
    .s_axis_tdata(core_tdata),
    .s_axis_tlast(core_tlast),
    .s_axis_tvalid(core_tvalid),
    .s_axis_tready(core_tready),
    .m_axis_tdata(m_axis_tdata),
    .m_axis_tuser(m_axis_tuser),
    .m_axis_tvalid(m_axis_tvalid),
    .m_axis_tlast(m_axis_tlast),
    .m_axis_tready(m_axis_tready),
    .events(events)
  );

endmodule

// File: test/ospfb_asserts.sv
`timescale 1ns/1ps
`include "ospfb_config.svh"

module ospfb_asserts (
  input wire logic clk,
  input wire logic reset,
  input wire logic frame_full,
  input wire logic accept,
  input wire ospfb_types_pkg::cplx_t out_data,
  input wire ospfb_types_pkg::frame_id_t out_user,
  input wire logic out_valid,
  input wire logic out_last,
  input wire logic out_ready
);
  import ospfb_types_pkg::*;

  localparam branch_idx_t LAST_IDX = branch_idx_t'(`OSPFB_FFT_LEN - 1);

  // output transfers within the current frame
  branch_idx_t beat;
  // from frame_full until the last word of the frame leaves
  logic busy;
  // read by the testbench monitor
  int fail_count = 0;

  always_ff @(posedge clk) begin
    if (reset) begin
      beat <= '0;
      busy <= 1'b0;
    end else begin
      if (out_valid && out_ready) begin
        beat <= beat + 1'b1;
      end
      if (frame_full) begin
        busy <= 1'b1;
      end else if (out_valid && out_ready && out_last) begin
        busy <= 1'b0;
      end
    end
  end

  // stalled word stays put until taken
  hold_under_backpressure: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last)
      && $stable(out_user))
    else begin
      fail_count++;
      $error("output word changed while stalled");
    end

  // history frozen while a frame is out
  no_accept_while_busy: assert property (@(posedge clk) disable iff (reset)
    (frame_full || busy) |-> !accept)
    else begin
      fail_count++;
      $error("accept high while a frame is being emitted");
    end

  last_on_final_word: assert property (@(posedge clk) disable iff (reset)
    out_valid && out_last |-> beat == LAST_IDX)
    else begin
      fail_count++;
      $error("out_last on a word other than the last of the frame");
    end

endmodule

bind ospfb_sequencer ospfb_asserts seq_checks (
  .clk(clk),
  .reset(reset),
  .frame_full(frame_full),
  .accept(accept),
  .out_data(out_data),
  .out_user(out_user),
  .out_valid(out_valid),
  .out_last(out_last),
  .out_ready(out_ready)
);

// File: test/ospfb_tb.sv
`timescale 1ns/1ps
`include "ospfb_config.svh"

module ospfb_tb;
  import ospfb_types_pkg::*;
  import ospfb_coeff_pkg::*;

  localparam int M = `OSPFB_FFT_LEN;
  localparam int D = `OSPFB_DEC_FAC;
  localparam int P = `OSPFB_PTAPS;
  localparam int CLK_PERIOD = 20;
  // 1.0 in sample units, so the impulse response is the raw tap
  localparam int IMPULSE = 1 << `OSPFB_COEFF_FRAC;
  localparam logic [1:0] KIND_RAND = 2'd0;
  localparam logic [1:0] KIND_IMPULSE = 2'd1;
  localparam logic [1:0] KIND_ZERO = 2'd2;

  typedef struct packed {
    int n;
    // tlast position in the row, -1 for none
    int last_pos;
    logic en;
    // random tready and random input gaps
    logic stress;
    logic [1:0] kind;
    // reset before the row
    logic rst;
  } row_t;

  localparam int NUM_ROWS = 21;
  localparam row_t ROWS [NUM_ROWS] = '{
    // impulse walks through both taps, then leaves
    '{6, 5, 1'b1, 1'b0, KIND_IMPULSE, 1'b0},
    '{6, 5, 1'b1, 1'b0, KIND_ZERO, 1'b0},
    '{6, 5, 1'b1, 1'b0, KIND_ZERO, 1'b0},
    // eight random frames, two full rotation cycles
    '{6, 5, 1'b1, 1'b0, KIND_RAND, 1'b0},
    '{6, 5, 1'b1, 1'b0, KIND_RAND, 1'b0},
    '{6, 5, 1'b1, 1'b0, KIND_RAND, 1'b0},
    '{6, 5, 1'b1, 1'b0, KIND_RAND, 1'b0},
    '{6, 5, 1'b1, 1'b0, KIND_RAND, 1'b0},
    '{6, 5, 1'b1, 1'b0, KIND_RAND, 1'b0},
    '{6, 5, 1'b1, 1'b0, KIND_RAND, 1'b0},
    '{6, 5, 1'b1, 1'b0, KIND_RAND, 1'b0},
    // early tlast, then a frame with none
    '{6, 2, 1'b1, 1'b0, KIND_RAND, 1'b0},
    '{6, -1, 1'b1, 1'b0, KIND_RAND, 1'b0},
    // back-pressure and slow input
    '{6, 5, 1'b1, 1'b1, KIND_RAND, 1'b0},
    '{6, 5, 1'b1, 1'b1, KIND_RAND, 1'b0},
    '{6, 5, 1'b1, 1'b1, KIND_RAND, 1'b0},
    // samples held back by en
    '{6, 5, 1'b0, 1'b0, KIND_RAND, 1'b0},
    '{6, 5, 1'b1, 1'b0, KIND_RAND, 1'b0},
    // part of a frame, then reset on top of it
    '{3, -1, 1'b1, 1'b0, KIND_RAND, 1'b0},
    '{6, 5, 1'b1, 1'b0, KIND_RAND, 1'b1},
    '{6, 5, 1'b1, 1'b0, KIND_RAND, 1'b0}
  };

  logic s_clk;
  logic m_clk;
  logic reset;
  logic en;
  cplx_t s_axis_tdata;
  logic s_axis_tvalid;
  logic s_axis_tlast;
  logic s_axis_tready;
  cplx_t m_axis_tdata;
  frame_id_t m_axis_tuser;
  logic m_axis_tvalid;
  logic m_axis_tlast;
  logic m_axis_tready;
  ospfb_events_t events;

  logic [31:0] lfsr_state = 32'h1b6ce342;
  logic stress_mode = 1'b0;
  // model state, cleared with every reset
  cplx_t sent [$];
  ospfb_events_t exp_events [$];
  int rx_frame = 0;
  int rx_k = 0;

  ospfb_top DUT (
    .s_axis_aclk(s_clk),
    .m_axis_aclk(m_clk),
    .reset(reset),
    .en(en),
    .s_axis_tdata(s_axis_tdata),
    .s_axis_tvalid(s_axis_tvalid),
    .s_axis_tlast(s_axis_tlast),
    .s_axis_tready(s_axis_tready),
    .m_axis_tdata(m_axis_tdata),
    .m_axis_tuser(m_axis_tuser),
    .m_axis_tvalid(m_axis_tvalid),
    .m_axis_tlast(m_axis_tlast),
    .m_axis_tready(m_axis_tready),
    .events(events)
  );

  initial begin
    s_clk = 1'b0;
    forever #(CLK_PERIOD / 2) s_clk = ~s_clk;
  end

  // 7 ns phase offset from the input clock
  initial begin
    m_clk = 1'b0;
    #7;
    forever #(CLK_PERIOD / 2) m_clk = ~m_clk;
  end

  // galois form, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_cplx(input string name, input cplx_t got, input cplx_t exp);
    if (got !== exp) begin
      fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_user(input string name, input frame_id_t got, input frame_id_t exp);
    if (got !== exp) begin
      fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_events(input string name, input ospfb_events_t got,
                              input ospfb_events_t exp);
    if (got !== exp) begin
      fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  // word k of frame f straight from the filter bank rule
  function automatic cplx_t model_word(input int f, input int k);
    int rot;
    int br;
    int newest;
    int idx;
    longint acc_re;
    longint acc_im;
    cplx_t h;
    cplx_t r;
    rot = (f * D) % M;
    br = (k - rot + M) % M;
    newest = D * (f + 1) - 1;
    acc_re = 0;
    acc_im = 0;
    for (int p = 0; p < P; p++) begin
      // hist[j] is the sample j places before the newest
      idx = newest - (p * M + br);
      h = (idx >= 0) ? sent[idx] : '0;
      acc_re += longint'(taps[p * M + br]) * longint'(h.re);
      acc_im += longint'(taps[p * M + br]) * longint'(h.im);
    end
    r.re = sample_t'(acc_re >>> `OSPFB_COEFF_FRAC);
    r.im = sample_t'(acc_im >>> `OSPFB_COEFF_FRAC);
    return r;
  endfunction

  // entered at s edge plus 2 ns, left the same way
  task automatic send_sample(input cplx_t d, input logic last);
    ospfb_events_t ev;
    logic hs;
    int pos;
    pos = sent.size() % D;
    sent.push_back(d);
    // framing checks follow the position modulo D
    ev = '0;
    ev.tlast_unexpected = last && (pos != D - 1);
    ev.tlast_missing = !last && (pos == D - 1);
    if (ev != '0) begin
      exp_events.push_back(ev);
    end
    if (pos == D - 1) begin
      ev = '0;
      ev.frame_started = 1'b1;
      exp_events.push_back(ev);
    end
    s_axis_tdata = d;
    s_axis_tlast = last;
    s_axis_tvalid = 1'b1;
    hs = 1'b0;
    while (!hs) begin
      @(negedge s_clk);
      hs = s_axis_tready;
      @(posedge s_clk);
      #2;
    end
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
  endtask

  task automatic send_row(input row_t row);
    cplx_t d;
    for (int i = 0; i < row.n; i++) begin
      if (row.kind == KIND_RAND) begin
        d.re = sample_t'(rand_bits(16));
        d.im = sample_t'(rand_bits(16));
      end else if (row.kind == KIND_IMPULSE && i == 0) begin
        d.re = sample_t'(IMPULSE);
        d.im = sample_t'(-IMPULSE);
      end else begin
        d = '0;
      end
      if (row.stress) begin
        repeat (rand_bits(2)) begin
          @(posedge s_clk);
          #2;
        end
      end
      send_sample(d, i == row.last_pos);
    end
  endtask

  // all complete frames out, back on the input drive point
  task automatic wait_idle();
    while (rx_frame < sent.size() / D) begin
      @(posedge m_clk);
    end
    repeat (2) @(posedge m_clk);
    @(posedge s_clk);
    #2;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (2) @(posedge m_clk);
    @(posedge s_clk);
    #2;
    // fifo write side held off while in reset
    if (s_axis_tready !== 1'b0) begin
      fail_now("input ready is high during reset");
    end
    sent.delete();
    exp_events.delete();
    rx_frame = 0;
    rx_k = 0;
    reset = 1'b0;
    @(negedge m_clk);
    check_events("events", events, '0);
    if (m_axis_tvalid !== 1'b0) begin
      fail_now("output valid is high right after reset");
    end
    @(posedge s_clk);
    #2;
  endtask

  // output ready, random only under stress
  initial begin
    logic [31:0] bits;
    m_axis_tready = 1'b1;
    forever begin
      @(posedge m_clk);
      #2;
      if (stress_mode) begin
        bits = rand_bits(1);
        m_axis_tready = bits[0];
      end else begin
        m_axis_tready = 1'b1;
      end
    end
  end

  // negedge sees the values for the coming transfer edge
  always @(negedge m_clk) begin
    if (!reset) begin
      if (DUT.ospfb_inst.sequencer_inst.seq_checks.fail_count != 0) begin
        fail_now("a sequencer assertion failed");
      end
      if (m_axis_tvalid && m_axis_tready) begin
        check_cplx($sformatf("m_axis_tdata frame %0d word %0d", rx_frame, rx_k),
                   m_axis_tdata, model_word(rx_frame, rx_k));
        check_user($sformatf("m_axis_tuser frame %0d", rx_frame),
                   m_axis_tuser, frame_id_t'(rx_frame));
        check_last($sformatf("m_axis_tlast frame %0d word %0d", rx_frame, rx_k),
                   m_axis_tlast, rx_k == M - 1);
        if (rx_k == M - 1) begin
          rx_k = 0;
          rx_frame++;
        end else begin
          rx_k++;
        end
      end
      if (events != '0) begin
        if (exp_events.size() == 0) begin
          fail_now("event pulse seen when none was expected");
        end else begin
          check_events("events", events, exp_events.pop_front());
        end
      end
    end
  end

  // 50 output clocks per table sample plus slack for resets and idle waits
  initial begin
    int total;
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += ROWS[r].n;
    end
    #(total * 50 * CLK_PERIOD + 5000);
    fail_now("timeout, the run did not complete in the allowed time");
  end

  initial begin
    int words;
    reset = 1'b1;
    en = 1'b0;
    s_axis_tdata = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
    apply_reset();
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (ROWS[r].rst || !ROWS[r].en) begin
        wait_idle();
      end
      if (ROWS[r].rst) begin
        // unfinished frame settles into the history first
        repeat (10) @(posedge m_clk);
        @(posedge s_clk);
        #2;
        apply_reset();
      end
      en = ROWS[r].en;
      stress_mode = ROWS[r].stress;
      send_row(ROWS[r]);
      if (!ROWS[r].en) begin
        words = rx_frame * M + rx_k;
        repeat (20) @(posedge m_clk);
        if (rx_frame * M + rx_k != words) begin
          fail_now("output produced while en was low");
        end
        @(posedge s_clk);
        #2;
      end
    end
    wait_idle();
    repeat (5) @(posedge m_clk);
    if (exp_events.size() != 0) begin
      fail_now($sformatf("%0d expected event pulses never came", exp_events.size()));
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// File: build.f
+incdir+source
source/ospfb_types_pkg.sv
source/ospfb_coeff_pkg.sv
source/cdc_axis_fifo.sv
source/pfb_history.sv
source/pfb_branch_sum.sv
source/ospfb_sequencer.sv
source/ospfb.sv
source/ospfb_top.sv
test/ospfb_asserts.sv
test/ospfb_tb.sv
